//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = tb_cpu_core
FILE_LIST = list.f
BUILD_DIR = obj_dir

.PHONY: simulate clean

simulate:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/stage_decode.sv
logic/stage_issue.sv
logic/stage_execute.sv
logic/stage_writeback.sv
logic/cpu_core_top.sv
testbench/cpu_core_checker.sv
testbench/tb_cpu_core.sv

//--- logic/cpu_core_top.sv
`timescale 1ns/1ps

module cpu_core_top (
    input  logic                  cpu_clk_i,
    input  logic                  rst_n_i,
    input  isa_pkg::instr_t       instr_i,
    input  logic                  instr_valid_i,
    output logic                  instr_ready_o,
    output pipe_pkg::result_pkt_t result_o,
    output logic                  result_valid_o,
    input  logic                  result_ready_i
);

    // Decode to issue
    pipe_pkg::decode_pkt_t decode_pkt;
    logic                  decode_valid;
    logic                  decode_ready;

    // Issue to execute
    pipe_pkg::issue_pkt_t  issue_pkt;
    logic                  issue_valid;
    logic                  issue_ready;

    // Execute to writeback
    pipe_pkg::result_pkt_t exec_pkt;
    logic                  exec_valid;
    logic                  exec_ready;

    // Register file and scoreboard side paths
    isa_pkg::reg_idx_t     rf_idx_a;
    isa_pkg::reg_idx_t     rf_idx_b;
    isa_pkg::word_t        rf_data_a;
    isa_pkg::word_t        rf_data_b;
    logic                  rf_wr_en;
    isa_pkg::reg_idx_t     rf_wr_idx;
    isa_pkg::word_t        rf_wr_data;
    logic                  clear_en;
    isa_pkg::reg_idx_t     clear_idx;

    stage_decode stage_decode (
        .cpu_clk_i      (cpu_clk_i),
        .rst_n_i        (rst_n_i),
        .instr_i        (instr_i),
        .instr_valid_i  (instr_valid_i),
        .instr_ready_o  (instr_ready_o),
        .decode_o       (decode_pkt),
        .decode_valid_o (decode_valid),
        .decode_ready_i (decode_ready)
    );

    stage_issue stage_issue (
        .cpu_clk_i      (cpu_clk_i),
        .rst_n_i        (rst_n_i),
        .decode_i       (decode_pkt),
        .decode_valid_i (decode_valid),
        .decode_ready_o (decode_ready),
        .rf_idx_a_o     (rf_idx_a),
        .rf_idx_b_o     (rf_idx_b),
        .rf_data_a_i    (rf_data_a),
        .rf_data_b_i    (rf_data_b),
        .clear_en_i     (clear_en),
        .clear_idx_i    (clear_idx),
        .issue_o        (issue_pkt),
        .issue_valid_o  (issue_valid),
        .issue_ready_i  (issue_ready)
    );

    stage_execute stage_execute (
        .cpu_clk_i     (cpu_clk_i),
        .rst_n_i       (rst_n_i),
        .issue_i       (issue_pkt),
        .issue_valid_i (issue_valid),
        .issue_ready_o (issue_ready),
        .exec_o        (exec_pkt),
        .exec_valid_o  (exec_valid),
        .exec_ready_i  (exec_ready)
    );

    stage_writeback stage_writeback (
        .cpu_clk_i      (cpu_clk_i),
        .rst_n_i        (rst_n_i),
        .exec_i         (exec_pkt),
        .exec_valid_i   (exec_valid),
        .exec_ready_o   (exec_ready),
        .rf_wr_en_o     (rf_wr_en),
        .rf_wr_idx_o    (rf_wr_idx),
        .rf_wr_data_o   (rf_wr_data),
        .clear_en_o     (clear_en),
        .clear_idx_o    (clear_idx),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

    reg_file reg_file (
        .cpu_clk_i   (cpu_clk_i),
        .rst_n_i     (rst_n_i),
        .rd_idx_a_i  (rf_idx_a),
        .rd_idx_b_i  (rf_idx_b),
        .rd_data_a_o (rf_data_a),
        .rd_data_b_o (rf_data_b),
        .wr_en_i     (rf_wr_en),
        .wr_idx_i    (rf_wr_idx),
        .wr_data_i   (rf_wr_data)
    );

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

    localparam int NUM_REGS = 16;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    // Codes above OP_NOP are illegal
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLL  = 4'h5,
        OP_SRL  = 4'h6,
        OP_ADDI = 4'h7,
        OP_LUI  = 4'h8,
        OP_NOP  = 4'h9
    } opcode_t;

    typedef struct packed {
        opcode_t     opcode;  // [31:28]
        reg_idx_t    rd;      // [27:24]
        reg_idx_t    ra;      // [23:20]
        reg_idx_t    rb;      // [19:16]
        logic [15:0] unused;
    } instr_rtype_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    ra;
        logic [19:0] imm;     // Signed for ADDI, upper bits for LUI
    } instr_itype_t;

    // Same word seen as register form or immediate form
    typedef union packed {
        instr_rtype_t r;
        instr_itype_t i;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;    // Operand b comes from imm
        word_t   imm;        // Already extended or shifted
        logic    writes_rd;
        logic    illegal;
    } control_word_t;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    // Instruction plus result, so four registered stages
    localparam int PIPE_DEPTH = 4;

    // Decode to issue
    typedef struct packed {
        isa_pkg::control_word_t cw;
        isa_pkg::reg_idx_t      rd;
        isa_pkg::reg_idx_t      ra;  // Zero when not read
        isa_pkg::reg_idx_t      rb;  // Zero when not read
    } decode_pkt_t;

    // Issue to execute, operands already resolved
    typedef struct packed {
        isa_pkg::control_word_t cw;
        isa_pkg::reg_idx_t      rd;
        isa_pkg::word_t         op_a;
        isa_pkg::word_t         op_b;
    } issue_pkt_t;

    // Execute to writeback and out of the core
    typedef struct packed {
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    data;
        logic              writes_rd;
        logic              illegal;
    } result_pkt_t;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              cpu_clk_i,
    input  logic              rst_n_i,
    input  isa_pkg::reg_idx_t rd_idx_a_i,
    input  isa_pkg::reg_idx_t rd_idx_b_i,
    output isa_pkg::word_t    rd_data_a_o,
    output isa_pkg::word_t    rd_data_b_o,
    input  logic              wr_en_i,
    input  isa_pkg::reg_idx_t wr_idx_i,
    input  isa_pkg::word_t    wr_data_i
);

    isa_pkg::word_t regs_q [isa_pkg::NUM_REGS];

    // Write-first read with r0 tied low
    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wr_en_i && (wr_idx_i == idx))
            return wr_data_i;  // Bypass the write in flight
        return regs_q[idx];
    endfunction

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    always_comb begin
        rd_data_a_o = read_port(rd_idx_a_i);
        rd_data_b_o = read_port(rd_idx_b_i);
    end

endmodule

//--- logic/stage_decode.sv
`timescale 1ns/1ps

module stage_decode (
    input  logic                 cpu_clk_i,
    input  logic                 rst_n_i,
    input  isa_pkg::instr_t      instr_i,
    input  logic                 instr_valid_i,
    output logic                 instr_ready_o,
    output pipe_pkg::decode_pkt_t decode_o,
    output logic                 decode_valid_o,
    input  logic                 decode_ready_i
);

    isa_pkg::control_word_t cw;
    pipe_pkg::decode_pkt_t  decode_d;
    logic                   reads_ra;
    logic                   reads_rb;
    logic                   accept;

    always_comb begin
        cw           = '0;
        cw.writes_rd = 1'b1;
        reads_ra     = 1'b1;
        reads_rb     = 1'b1;
        case (instr_i.r.opcode)
            isa_pkg::OP_ADD: cw.alu_op = isa_pkg::ALU_ADD;
            isa_pkg::OP_SUB: cw.alu_op = isa_pkg::ALU_SUB;
            isa_pkg::OP_AND: cw.alu_op = isa_pkg::ALU_AND;
            isa_pkg::OP_OR:  cw.alu_op = isa_pkg::ALU_OR;
            isa_pkg::OP_XOR: cw.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::OP_SLL: cw.alu_op = isa_pkg::ALU_SLL;
            isa_pkg::OP_SRL: cw.alu_op = isa_pkg::ALU_SRL;
            isa_pkg::OP_ADDI: begin
                cw.alu_op  = isa_pkg::ALU_ADD;
                cw.use_imm = 1'b1;
                cw.imm     = {{12{instr_i.i.imm[19]}}, instr_i.i.imm};
                reads_rb   = 1'b0;  // Bits 19:16 belong to imm here
            end
            isa_pkg::OP_LUI: begin
                cw.alu_op  = isa_pkg::ALU_PASS_B;
                cw.use_imm = 1'b1;
                cw.imm     = {instr_i.i.imm, 12'h000};
                reads_ra   = 1'b0;
                reads_rb   = 1'b0;
            end
            isa_pkg::OP_NOP: begin
                cw.writes_rd = 1'b0;
                reads_ra     = 1'b0;
                reads_rb     = 1'b0;
            end
            default: begin
                cw.writes_rd = 1'b0;
                cw.illegal   = 1'b1;
                reads_ra     = 1'b0;
                reads_rb     = 1'b0;
            end
        endcase
    end

    // Unread sources go to r0 so they never hit the scoreboard
    always_comb begin
        decode_d.cw = cw;
        decode_d.rd = instr_i.r.rd;
        decode_d.ra = reads_ra ? instr_i.r.ra : '0;
        decode_d.rb = reads_rb ? instr_i.r.rb : '0;
    end

    assign instr_ready_o = !decode_valid_o || decode_ready_i;
    assign accept        = instr_valid_i && instr_ready_o;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i)
            decode_valid_o <= 1'b0;
        else if (accept)
            decode_valid_o <= 1'b1;
        else if (decode_ready_i)
            decode_valid_o <= 1'b0;  // Taken, nothing new behind it
    end

    always_ff @(posedge cpu_clk_i) begin
        if (accept)
            decode_o <= decode_d;
    end

endmodule

//--- logic/stage_execute.sv
`timescale 1ns/1ps

module stage_execute (
    input  logic                  cpu_clk_i,
    input  logic                  rst_n_i,
    input  pipe_pkg::issue_pkt_t  issue_i,
    input  logic                  issue_valid_i,
    output logic                  issue_ready_o,
    output pipe_pkg::result_pkt_t exec_o,
    output logic                  exec_valid_o,
    input  logic                  exec_ready_i
);

    isa_pkg::word_t        alu_out;
    pipe_pkg::result_pkt_t exec_d;
    logic                  accept;

    always_comb begin
        case (issue_i.cw.alu_op)
            isa_pkg::ALU_ADD:    alu_out = issue_i.op_a + issue_i.op_b;
            isa_pkg::ALU_SUB:    alu_out = issue_i.op_a - issue_i.op_b;
            isa_pkg::ALU_AND:    alu_out = issue_i.op_a & issue_i.op_b;
            isa_pkg::ALU_OR:     alu_out = issue_i.op_a | issue_i.op_b;
            isa_pkg::ALU_XOR:    alu_out = issue_i.op_a ^ issue_i.op_b;
            isa_pkg::ALU_SLL:    alu_out = issue_i.op_a << issue_i.op_b[4:0];
            isa_pkg::ALU_SRL:    alu_out = issue_i.op_a >> issue_i.op_b[4:0];
            default:             alu_out = issue_i.op_b;  // PASS_B for LUI
        endcase
    end

    always_comb begin
        exec_d.rd        = issue_i.rd;
        exec_d.data      = issue_i.cw.writes_rd ? alu_out : '0;  // NOP and illegal give 0
        exec_d.writes_rd = issue_i.cw.writes_rd;
        exec_d.illegal   = issue_i.cw.illegal;
    end

    assign issue_ready_o = !exec_valid_o || exec_ready_i;
    assign accept        = issue_valid_i && issue_ready_o;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i)
            exec_valid_o <= 1'b0;
        else if (accept)
            exec_valid_o <= 1'b1;
        else if (exec_ready_i)
            exec_valid_o <= 1'b0;
    end

    always_ff @(posedge cpu_clk_i) begin
        if (accept)
            exec_o <= exec_d;
    end

endmodule

//--- logic/stage_issue.sv
`timescale 1ns/1ps

module stage_issue (
    input  logic                  cpu_clk_i,
    input  logic                  rst_n_i,
    input  pipe_pkg::decode_pkt_t decode_i,
    input  logic                  decode_valid_i,
    output logic                  decode_ready_o,
    output isa_pkg::reg_idx_t     rf_idx_a_o,
    output isa_pkg::reg_idx_t     rf_idx_b_o,
    input  isa_pkg::word_t        rf_data_a_i,
    input  isa_pkg::word_t        rf_data_b_i,
    input  logic                  clear_en_i,
    input  isa_pkg::reg_idx_t     clear_idx_i,
    output pipe_pkg::issue_pkt_t  issue_o,
    output logic                  issue_valid_o,
    input  logic                  issue_ready_i
);

    logic [isa_pkg::NUM_REGS-1:0] pending_q;    // Destinations still in flight
    logic [isa_pkg::NUM_REGS-1:0] clr_mask;
    logic [isa_pkg::NUM_REGS-1:0] set_mask;
    logic [isa_pkg::NUM_REGS-1:0] pending_eff;  // Ignoring the bit cleared now
    logic                         src_hazard;
    logic                         dst_hazard;
    logic                         hazard;
    logic                         out_free;
    logic                         issue_fire;
    pipe_pkg::issue_pkt_t         issue_d;

    assign rf_idx_a_o = decode_i.ra;
    assign rf_idx_b_o = decode_i.rb;

    always_comb begin
        clr_mask = '0;
        if (clear_en_i)
            clr_mask[clear_idx_i] = 1'b1;
    end

    assign pending_eff = pending_q & ~clr_mask;

    // RAW on either source, WAW on the destination
    assign src_hazard = pending_eff[decode_i.ra] || pending_eff[decode_i.rb];
    assign dst_hazard = decode_i.cw.writes_rd && pending_eff[decode_i.rd];
    assign hazard     = src_hazard || dst_hazard;

    assign out_free       = !issue_valid_o || issue_ready_i;
    assign decode_ready_o = out_free && !hazard;
    assign issue_fire     = decode_valid_i && decode_ready_o;

    // r0 is never tracked
    always_comb begin
        set_mask = '0;
        if (issue_fire && decode_i.cw.writes_rd && (decode_i.rd != '0))
            set_mask[decode_i.rd] = 1'b1;
    end

    always_comb begin
        issue_d.cw   = decode_i.cw;
        issue_d.rd   = decode_i.rd;
        issue_d.op_a = rf_data_a_i;
        issue_d.op_b = decode_i.cw.use_imm ? decode_i.cw.imm : rf_data_b_i;
    end

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            pending_q     <= '0;
            issue_valid_o <= 1'b0;
        end else begin
            pending_q <= pending_eff | set_mask;  // Set wins over clear on same reg
            if (issue_fire)
                issue_valid_o <= 1'b1;
            else if (issue_ready_i)
                issue_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (issue_fire)
            issue_o <= issue_d;
    end

endmodule

//--- logic/stage_writeback.sv
`timescale 1ns/1ps

module stage_writeback (
    input  logic                  cpu_clk_i,
    input  logic                  rst_n_i,
    input  pipe_pkg::result_pkt_t exec_i,
    input  logic                  exec_valid_i,
    output logic                  exec_ready_o,
    output logic                  rf_wr_en_o,
    output isa_pkg::reg_idx_t     rf_wr_idx_o,
    output isa_pkg::word_t        rf_wr_data_o,
    output logic                  clear_en_o,
    output isa_pkg::reg_idx_t     clear_idx_o,
    output pipe_pkg::result_pkt_t result_o,
    output logic                  result_valid_o,
    input  logic                  result_ready_i
);

    logic accept;

    assign exec_ready_o = !result_valid_o || result_ready_i;
    assign accept       = exec_valid_i && exec_ready_o;

    // Register file write and scoreboard clear land on the same edge
    assign rf_wr_en_o   = accept && exec_i.writes_rd && (exec_i.rd != '0);
    assign rf_wr_idx_o  = exec_i.rd;
    assign rf_wr_data_o = exec_i.data;
    assign clear_en_o   = accept && exec_i.writes_rd;
    assign clear_idx_o  = exec_i.rd;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i)
            result_valid_o <= 1'b0;
        else if (accept)
            result_valid_o <= 1'b1;
        else if (result_ready_i)
            result_valid_o <= 1'b0;
    end

    always_ff @(posedge cpu_clk_i) begin
        if (accept)
            result_o <= exec_i;  // Held until the consumer takes it
    end

endmodule

//--- testbench/cpu_core_checker.sv
`timescale 1ns/1ps

module cpu_core_checker (
    input logic                         cpu_clk_i,
    input logic                         rst_n_i,
    input pipe_pkg::decode_pkt_t        decode_i,
    input logic                         decode_valid_i,
    input logic                         decode_ready_i,
    input logic [isa_pkg::NUM_REGS-1:0] pending_i,
    input logic                         clear_en_i,
    input isa_pkg::reg_idx_t            clear_idx_i,
    input pipe_pkg::issue_pkt_t         issue_i,
    input logic                         issue_valid_i,
    input logic                         issue_ready_i
);

    int unsigned                  fail_count = 0;  // Assertion failures so far
    logic [isa_pkg::NUM_REGS-1:0] live_mask;
    logic                         issue_fire;
    logic                         blocked;

    always_comb begin
        live_mask = pending_i;
        if (clear_en_i)
            live_mask[clear_idx_i] = 1'b0;  // Retiring this cycle
    end

    assign issue_fire = decode_valid_i && decode_ready_i;
    assign blocked    = live_mask[decode_i.ra] || live_mask[decode_i.rb]
                        || (decode_i.cw.writes_rd && live_mask[decode_i.rd]);

    no_hazard_issue: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        issue_fire |-> !blocked)
        else begin
            $error("Issue fired on a pending register");
            fail_count++;
        end

    // Held packet stays put under back-pressure
    issue_held_stable: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (issue_valid_i && !issue_ready_i) |=> (issue_valid_i && $stable(issue_i)))
        else begin
            $error("issue_o changed while stalled");
            fail_count++;
        end

    valid_low_after_reset: assert property (@(posedge cpu_clk_i)
        !rst_n_i |=> !issue_valid_i)
        else begin
            $error("issue_valid_o high after reset");
            fail_count++;
        end

endmodule

bind stage_issue cpu_core_checker issue_checker (
    .cpu_clk_i      (cpu_clk_i),
    .rst_n_i        (rst_n_i),
    .decode_i       (decode_i),
    .decode_valid_i (decode_valid_i),
    .decode_ready_i (decode_ready_o),
    .pending_i      (pending_q),
    .clear_en_i     (clear_en_i),
    .clear_idx_i    (clear_idx_i),
    .issue_i        (issue_o),
    .issue_valid_i  (issue_valid_o),
    .issue_ready_i  (issue_ready_i)
);

//--- testbench/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

    localparam int TIMEOUT = 200;  // Edges per wait

    logic                  cpu_clk;
    logic                  rst_n;
    isa_pkg::instr_t       instr;
    logic                  instr_valid;
    logic                  instr_ready;
    pipe_pkg::result_pkt_t result;
    logic                  result_valid;
    logic                  result_ready;

    isa_pkg::word_t        model_regs [isa_pkg::NUM_REGS];
    pipe_pkg::result_pkt_t exp_q [$];
    int                    result_cycles [$];
    int                    cycle_cnt = 0;
    int                    first_accept;
    int                    stall_edges;

    cpu_core_top dut (
        .cpu_clk_i      (cpu_clk),
        .rst_n_i        (rst_n),
        .instr_i        (instr),
        .instr_valid_i  (instr_valid),
        .instr_ready_o  (instr_ready),
        .result_o       (result),
        .result_valid_o (result_valid),
        .result_ready_i (result_ready)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #5 cpu_clk = ~cpu_clk;
    end

    always @(posedge cpu_clk)
        cycle_cnt <= cycle_cnt + 1;

    // Bound issue checker counts its assertion failures
    always @(posedge cpu_clk) begin
        if (dut.stage_issue.issue_checker.fail_count != 0)
            abort_run("Issue stage assertion failed");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    task automatic compare_result(input pipe_pkg::result_pkt_t got,
                                  input pipe_pkg::result_pkt_t exp);
        check_value("result_o.rd", 32'(got.rd), 32'(exp.rd));
        check_value("result_o.data", got.data, exp.data);
        check_value("result_o.writes_rd", 32'(got.writes_rd), 32'(exp.writes_rd));
        check_value("result_o.illegal", 32'(got.illegal), 32'(exp.illegal));
    endtask

    function automatic logic [31:0] enc_r(input logic [3:0] op, input logic [3:0] rd,
                                          input logic [3:0] ra, input logic [3:0] rb);
        return {op, rd, ra, rb, 16'h0000};
    endfunction

    function automatic logic [31:0] enc_i(input logic [3:0] op, input logic [3:0] rd,
                                          input logic [3:0] ra, input logic [19:0] imm);
        return {op, rd, ra, imm};
    endfunction

    // Reference model, one instruction in program order
    function automatic pipe_pkg::result_pkt_t model_step(input logic [31:0] w);
        pipe_pkg::result_pkt_t pkt;
        logic [31:0]           a;
        logic [31:0]           b;
        a             = model_regs[w[23:20]];
        b             = model_regs[w[19:16]];
        pkt.rd        = w[27:24];
        pkt.data      = '0;
        pkt.writes_rd = 1'b1;
        pkt.illegal   = 1'b0;
        case (w[31:28])
            isa_pkg::OP_ADD:  pkt.data = a + b;
            isa_pkg::OP_SUB:  pkt.data = a - b;
            isa_pkg::OP_AND:  pkt.data = a & b;
            isa_pkg::OP_OR:   pkt.data = a | b;
            isa_pkg::OP_XOR:  pkt.data = a ^ b;
            isa_pkg::OP_SLL:  pkt.data = a << b[4:0];
            isa_pkg::OP_SRL:  pkt.data = a >> b[4:0];
            isa_pkg::OP_ADDI: pkt.data = a + {{12{w[19]}}, w[19:0]};
            isa_pkg::OP_LUI:  pkt.data = {w[19:0], 12'h000};
            isa_pkg::OP_NOP:  pkt.writes_rd = 1'b0;
            default: begin
                pkt.writes_rd = 1'b0;
                pkt.illegal   = 1'b1;
            end
        endcase
        if (pkt.writes_rd && (pkt.rd != 4'h0))
            model_regs[pkt.rd] = pkt.data;  // r0 stays zero
        return pkt;
    endfunction

    function automatic logic ready_choice(input int edges, input int hold_off,
                                          input bit random_ready);
        if (edges < hold_off)
            return 1'b0;
        if (random_ready)
            return ($urandom % 2) == 1;
        return 1'b1;
    endfunction

    task automatic send_all(input logic [31:0] prog [$]);
        int waited;
        for (int i = 0; i < prog.size(); i++) begin
            instr       <= prog[i];
            instr_valid <= 1'b1;
            waited = 0;
            do begin
                @(posedge cpu_clk);
                waited++;
                if (!instr_ready)
                    stall_edges++;
                if (waited > TIMEOUT)
                    abort_run("Timeout: instr_ready_o stayed low");
            end while (!instr_ready);
            if (i == 0)
                first_accept = cycle_cnt;
        end
        instr_valid <= 1'b0;
    endtask

    task automatic collect_results(input int count, input bit random_ready, input int hold_off);
        pipe_pkg::result_pkt_t held;
        logic                  was_held;
        int                    got;
        int                    waited;
        int                    edges;
        got      = 0;
        waited   = 0;
        edges    = 0;
        was_held = 1'b0;
        result_ready <= ready_choice(0, hold_off, random_ready);
        while (got < count) begin
            @(posedge cpu_clk);
            edges++;
            waited++;
            if (was_held) begin  // Stalled packet must not move
                check_value("result_valid_o", 32'(result_valid), 32'h1);
                compare_result(result, held);
            end
            was_held = result_valid && !result_ready;
            held     = result;
            if (result_valid && result_ready) begin
                compare_result(result, exp_q.pop_front());
                result_cycles.push_back(cycle_cnt);
                got++;
                waited = 0;
            end
            if (waited > TIMEOUT)
                abort_run("Timeout: no result transfer on result_valid_o");
            result_ready <= ready_choice(edges, hold_off, random_ready);
        end
    endtask

    task automatic run_program(input logic [31:0] prog [$], input bit random_ready,
                               input int hold_off);
        exp_q.delete();
        result_cycles.delete();
        stall_edges = 0;
        foreach (prog[i])
            exp_q.push_back(model_step(prog[i]));
        fork
            send_all(prog);
            collect_results(prog.size(), random_ready, hold_off);
        join
        result_ready <= 1'b1;
        repeat (pipe_pkg::PIPE_DEPTH + 1) begin  // Nothing extra may follow
            @(posedge cpu_clk);
            check_value("result_valid_o", 32'(result_valid), 32'h0);
        end
    endtask

    task automatic test_reset();
        int waited;
        rst_n <= 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(posedge cpu_clk);
            if (i > 0)
                check_value("result_valid_o", 32'(result_valid), 32'h0);
        end
        rst_n <= 1'b1;
        waited = 0;
        do begin
            @(posedge cpu_clk);
            waited++;
            check_value("result_valid_o", 32'(result_valid), 32'h0);
            if (waited > TIMEOUT)
                abort_run("Timeout: instr_ready_o never rose after reset");
        end while (!instr_ready);
    endtask

    task automatic test_independent();
        logic [31:0] prog [$];
        prog.push_back(enc_i(isa_pkg::OP_LUI, 4'd4, 4'd0, 20'h12345));  // Sources r4..r9
        prog.push_back(enc_i(isa_pkg::OP_LUI, 4'd5, 4'd0, 20'h00F0F));
        prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'd6, 4'd0, 20'h00007));
        prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'd7, 4'd0, 20'hFFFFD));
        prog.push_back(enc_i(isa_pkg::OP_LUI, 4'd8, 4'd0, 20'h80000));
        prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'd9, 4'd0, 20'h00123));
        run_program(prog, 1'b0, 0);
        prog.delete();
        prog.push_back(enc_i(isa_pkg::OP_LUI, 4'd1, 4'd0, 20'hABCDE));
        prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'd2, 4'd4, 20'hFFFF0));
        prog.push_back(enc_r(isa_pkg::OP_ADD, 4'd10, 4'd4, 4'd5));
        prog.push_back(enc_r(isa_pkg::OP_SUB, 4'd11, 4'd5, 4'd7));
        prog.push_back(enc_r(isa_pkg::OP_AND, 4'd12, 4'd4, 4'd8));
        prog.push_back(enc_r(isa_pkg::OP_OR, 4'd13, 4'd5, 4'd9));
        prog.push_back(enc_r(isa_pkg::OP_XOR, 4'd14, 4'd4, 4'd9));
        prog.push_back(enc_r(isa_pkg::OP_SLL, 4'd15, 4'd9, 4'd6));
        prog.push_back(enc_r(isa_pkg::OP_SRL, 4'd3, 4'd8, 4'd6));
        run_program(prog, 1'b0, 0);
        check_value("result_valid_o latency", 32'(result_cycles[0] - first_accept),
                    32'(pipe_pkg::PIPE_DEPTH));
        for (int i = 1; i < result_cycles.size(); i++)
            check_value("result_valid_o spacing",
                        32'(result_cycles[i] - result_cycles[i - 1]), 32'd1);
    endtask

    // Each step reads the one before, r5 written twice in a row
    task automatic run_chain(input bit random_ready, input int hold_off);
        logic [31:0] prog [$];
        prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'd1, 4'd0, 20'h00005));
        prog.push_back(enc_r(isa_pkg::OP_ADD, 4'd2, 4'd1, 4'd1));
        prog.push_back(enc_r(isa_pkg::OP_SUB, 4'd3, 4'd2, 4'd9));
        prog.push_back(enc_r(isa_pkg::OP_SLL, 4'd4, 4'd3, 4'd1));
        prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'd5, 4'd4, 20'hFFFFF));
        prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'd5, 4'd5, 20'h00010));
        prog.push_back(enc_r(isa_pkg::OP_XOR, 4'd6, 4'd5, 4'd2));
        prog.push_back(enc_r(isa_pkg::OP_SRL, 4'd7, 4'd6, 4'd1));
        run_program(prog, random_ready, hold_off);
    endtask

    // No hazards here, so only the held output can stall the input
    task automatic test_backpressure();
        logic [31:0] prog [$];
        for (int i = 1; i < 9; i++)
            prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'(i), 4'd0, 20'(i * 3)));
        run_program(prog, 1'b1, 12);
        check_value("instr_ready_o low seen", 32'(stall_edges > 0), 32'h1);
    endtask

    task automatic test_special();
        logic [31:0] prog [$];
        prog.push_back(enc_i(isa_pkg::OP_ADDI, 4'd0, 4'd0, 20'h0007B));  // Write dropped
        prog.push_back(enc_r(isa_pkg::OP_OR, 4'd7, 4'd0, 4'd0));
        prog.push_back(enc_r(isa_pkg::OP_NOP, 4'd3, 4'd1, 4'd2));
        prog.push_back(enc_r(4'hA, 4'd2, 4'd1, 4'd1));
        prog.push_back(enc_r(4'hF, 4'd0, 4'd0, 4'd0));
        run_program(prog, 1'b0, 0);
    endtask

    task automatic test_random();
        logic [31:0] prog [$];
        logic [31:0] w;
        for (int i = 0; i < 200; i++) begin
            w        = $urandom;
            w[31:28] = 4'($urandom % 11);  // Code 10 is illegal
            prog.push_back(w);
        end
        run_program(prog, 1'b1, 0);
    endtask

    initial begin
        void'($urandom(46));
        instr        = '0;
        instr_valid  = 1'b0;
        result_ready = 1'b0;
        rst_n        = 1'b0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        test_reset();
        test_independent();
        run_chain(1'b0, 0);
        run_chain(1'b1, 12);  // Output held low while the stages fill
        test_backpressure();
        test_special();
        test_random();
        if (dut.stage_issue.issue_checker.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Issue stage assertions failed");
            $display("=== FAIL ===");
            $fatal(1, "Assertion failures");
        end
    end

endmodule
